/* sim.f */
hw/cam_display_pkg.sv
hw/vga_timing.sv
hw/frame_buffer.sv
hw/pixel_process.sv
hw/apb_regs.sv
hw/cam_display_top.sv
test/tb_cam_display_chk.sv
test/tb_cam_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_cam_display -f sim.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_cam_display +verilator+error+limit+100000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0

/* test/tb_cam_display.sv */
`timescale 1ns/1ps

module tb_cam_display;
    import cam_display_pkg::*;

    localparam int RESET_THRESHOLD = 64;
    // about five frames of 420,000 cycles, the fill and some margin
    localparam int TIMEOUT_CYCLES  = 2_600_000;

    logic              clk_25_vga;
    logic              arst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [3:0]        paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [PIX_W-1:0]  wr_data;
    logic [7:0]        vga_r;
    logic [7:0]        vga_g;
    logic [7:0]        vga_b;
    logic              vga_hsync;
    logic              vga_vsync;
    logic              vga_blank_n;

    logic [15:0] shadow [$];  // copy of the frame buffer contents
    int          err_cnt;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    int          chk_fails;

    cam_display_top u_cam_display_top (
        .clk_25_vga  (clk_25_vga),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_blank_n (vga_blank_n)
    );

    bind cam_display_top tb_cam_display_chk u_chk (
        .clk_25_vga  (clk_25_vga),
        .arst_n      (arst_n),
        .vga_hsync   (vga_hsync),
        .vga_blank_n (vga_blank_n),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .psel        (psel),
        .penable     (penable),
        .pready      (pready),
        .pslverr     (pslverr)
    );

    initial begin
        clk_25_vga = 1'b0;
        forever #5 clk_25_vga = ~clk_25_vga;
    end

    function automatic bit check_value(input string name, input int exp, input int act);
        bit ok;
        ok = 1'b1;
        assert (act == exp) else begin
            $display("** Error at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
            ok = 1'b0;
        end
        return ok;
    endfunction

    // rgb565 padded with ones, then the selected view
    function automatic void expected_pixel(input logic [15:0] word, input mode_e mode,
                                           input int thr, output int r, output int g,
                                           output int b);
        int gray;
        r    = int'(word[15:11]) * 8 + 7;
        g    = int'(word[10:5]) * 4 + 3;
        b    = int'(word[4:0]) * 8 + 7;
        gray = (76 * r + 150 * g + 26 * b) / 256;
        if (mode == MODE_GRAY) begin
            r = gray;
            g = gray;
            b = gray;
        end else if (mode == MODE_BINARY) begin
            r = (gray >= thr) ? 255 : 0;
            g = r;
            b = r;
        end
    endfunction

    task automatic report_test(input string name, input int errs);
        tests_run++;
        err_cnt += errs;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks failed", name, errs);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk_25_vga);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk_25_vga);
        penable <= 1'b1;
        @(negedge clk_25_vga);
        err = pslverr;  // valid in the access cycle
        @(posedge clk_25_vga);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk_25_vga);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk_25_vga);
        penable <= 1'b1;
        @(negedge clk_25_vga);
        data = prdata;
        err  = pslverr;
        @(posedge clk_25_vga);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_expect(input logic [3:0] addr, input string name,
                               input int exp_data, input int exp_err, inout int errs);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        if (!check_value({name, " pslverr"}, exp_err, int'(err))) errs++;
        if (exp_err == 0 && !check_value(name, exp_data, int'(data))) errs++;
    endtask

    task automatic fill_buffer;
        logic [15:0] word;
        int          a;
        for (a = 0; a < BUF_DEPTH; a++) begin
            word = 16'($urandom());
            shadow.push_back(word);
            @(posedge clk_25_vga);
            wr_en   <= 1'b1;
            wr_addr <= ADDR_W'(a);
            wr_data <= word;
        end
        @(posedge clk_25_vga);
        wr_en <= 1'b0;
    endtask

    // returns once the vsync pulse ends, ahead of line 0
    task automatic wait_frame_start;
        do begin
            @(negedge clk_25_vga);
        end while (vga_vsync);
        do begin
            @(negedge clk_25_vga);
        end while (!vga_vsync);
    endtask

    task automatic check_frame(input mode_e mode, input int thr, output int errs);
        int col;
        int line;
        int exp_r;
        int exp_g;
        int exp_b;
        errs = 0;
        col  = 0;
        line = 0;
        wait_frame_start();
        while (line < V_ACTIVE) begin
            @(negedge clk_25_vga);
            if (vga_blank_n && col < H_ACTIVE) begin
                // 2x upscale, each stored pixel covers a 2x2 block
                expected_pixel(shadow[(line / 2) * BUF_W + col / 2], mode, thr,
                               exp_r, exp_g, exp_b);
                if (!check_value("vga_r", exp_r, int'(vga_r))) errs++;
                if (!check_value("vga_g", exp_g, int'(vga_g))) errs++;
                if (!check_value("vga_b", exp_b, int'(vga_b))) errs++;
                col++;
            end else if (!vga_blank_n && col != 0) begin
                line++;
                col = 0;
            end
        end
    endtask

    task automatic test_reset_values;
        logic err;
        int   errs;
        errs = 0;
        read_expect(REG_CTRL, "REG_CTRL", 0, 0, errs);
        read_expect(REG_THRESHOLD, "REG_THRESHOLD", RESET_THRESHOLD, 0, errs);
        // frame 0 begins right after reset, so it is already counted
        read_expect(REG_STATUS, "REG_STATUS", 1, 0, errs);
        read_expect(4'hc, "offset 0xc", 0, 1, errs);
        apb_write(REG_STATUS, 32'h0000_1234, err);
        if (!check_value("REG_STATUS write pslverr", 1, int'(err))) errs++;
        read_expect(REG_CTRL, "REG_CTRL", 0, 0, errs);
        read_expect(REG_THRESHOLD, "REG_THRESHOLD", RESET_THRESHOLD, 0, errs);
        read_expect(REG_STATUS, "REG_STATUS", 1, 0, errs);
        report_test("reset_values", errs);
    endtask

    task automatic test_sync_structure;
        logic [31:0] s0;
        logic [31:0] s1;
        logic        err;
        logic        prev_hs;
        logic        prev_bl;
        int          errs;
        int          lines;
        int          act;
        int          low;
        int          cyc;
        int          last_fall;
        int          extra;
        errs      = 0;
        lines     = 0;
        act       = 0;
        low       = 0;
        cyc       = 0;
        last_fall = -1;
        extra     = 0;
        prev_hs   = 1'b1;
        prev_bl   = 1'b0;
        apb_read(REG_STATUS, s0, err);
        wait_frame_start();
        while (lines < V_ACTIVE) begin
            @(negedge clk_25_vga);
            cyc++;
            if (vga_blank_n) begin
                act++;
            end else if (prev_bl) begin
                if (!check_value("active cycles per line", H_ACTIVE, act)) errs++;
                act = 0;
                lines++;
            end
            if (!vga_hsync) low++;
            if (vga_hsync && !prev_hs) begin
                if (!check_value("hsync low cycles", H_SYNC, low)) errs++;
                low = 0;
            end
            if (!vga_hsync && prev_hs) begin
                if (last_fall >= 0 && !check_value("hsync period", H_TOTAL, cyc - last_fall))
                    errs++;
                last_fall = cyc;
            end
            prev_hs = vga_hsync;
            prev_bl = vga_blank_n;
        end
        // nothing active between line 479 and the next vsync pulse
        while (vga_vsync) begin
            @(negedge clk_25_vga);
            if (vga_blank_n) extra++;
        end
        if (!check_value("active cycles after last line", 0, extra)) errs++;
        apb_read(REG_STATUS, s1, err);
        if (!check_value("REG_STATUS", int'(s0) + 1, int'(s1))) errs++;
        report_test("sync_structure", errs);
    endtask

    task automatic test_rgb_mode;
        int errs;
        check_frame(MODE_RGB, RESET_THRESHOLD, errs);
        report_test("rgb_mode", errs);
    endtask

    task automatic test_gray_mode;
        logic [31:0] s0;
        logic [31:0] s1;
        logic        err;
        int          errs;
        int          frame_errs;
        errs = 0;
        apb_write(REG_CTRL, 32'd1, err);
        if (!check_value("REG_CTRL write pslverr", 0, int'(err))) errs++;
        apb_read(REG_STATUS, s0, err);
        check_frame(MODE_GRAY, RESET_THRESHOLD, frame_errs);
        errs += frame_errs;
        apb_read(REG_STATUS, s1, err);
        if (!check_value("REG_STATUS", int'(s0) + 1, int'(s1))) errs++;
        report_test("gray_mode", errs);
    endtask

    task automatic test_binary_mode;
        int   thr_list [3] = '{0, 128, 255};
        logic err;
        int   errs;
        int   frame_errs;
        errs = 0;
        apb_write(REG_CTRL, 32'd2, err);
        if (!check_value("REG_CTRL write pslverr", 0, int'(err))) errs++;
        foreach (thr_list[i]) begin
            apb_write(REG_THRESHOLD, 32'(thr_list[i]), err);
            if (!check_value("REG_THRESHOLD write pslverr", 0, int'(err))) errs++;
            check_frame(MODE_BINARY, thr_list[i], frame_errs);  // threshold 0 is all white
            errs += frame_errs;
        end
        report_test("binary_mode", errs);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_25_vga);
            cycles++;
        end
        $display("run stopped, no result after %0d cycles", cycles);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h76d1));
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        repeat (3) @(posedge clk_25_vga);
        arst_n <= 1'b1;
        test_reset_values();
        fill_buffer();
        // both watch frame 1
        fork
            test_sync_structure();
            test_rgb_mode();
        join
        test_gray_mode();
        test_binary_mode();
        chk_fails = u_cam_display_top.u_chk.fail_cnt;
        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, err_cnt, chk_fails);
        if (err_cnt == 0 && chk_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* test/tb_cam_display_chk.sv */
`timescale 1ns/1ps

module tb_cam_display_chk (
    input logic       clk_25_vga,
    input logic       arst_n,
    input logic       vga_hsync,
    input logic       vga_blank_n,
    input logic [7:0] vga_r,
    input logic [7:0] vga_g,
    input logic [7:0] vga_b,
    input logic       psel,
    input logic       penable,
    input logic       pready,
    input logic       pslverr
);
    import cam_display_pkg::*;

    int         fail_cnt = 0;  // read by the testbench at the end
    logic [7:0] hs_low_cnt;    // length of the current hsync pulse

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            hs_low_cnt <= '0;
        end else if (!vga_hsync) begin
            hs_low_cnt <= hs_low_cnt + 8'd1;
        end else begin
            hs_low_cnt <= '0;
        end
    end

    hsync_width: assert property (@(posedge clk_25_vga) disable iff (!arst_n)
        $rose(vga_hsync) |-> (hs_low_cnt == 8'(H_SYNC)))
        else begin
            $error("hsync pulse is not %0d cycles long", H_SYNC);
            fail_cnt++;
        end

    // black outside the active area
    blank_black: assert property (@(posedge clk_25_vga) disable iff (!arst_n)
        !vga_blank_n |-> (vga_r == 8'h00) && (vga_g == 8'h00) && (vga_b == 8'h00))
        else begin
            $error("colour output is not black while blanked");
            fail_cnt++;
        end

    access_ready: assert property (@(posedge clk_25_vga) disable iff (!arst_n)
        (psel && penable) |-> pready)
        else begin
            $error("pready low during an access cycle");
            fail_cnt++;
        end

    idle_no_err: assert property (@(posedge clk_25_vga) disable iff (!arst_n)
        !psel |-> !pslverr)
        else begin
            $error("pslverr high with psel low");
            fail_cnt++;
        end

endmodule

/* hw/cam_display_top.sv */
`timescale 1ns/1ps

module cam_display_top #(
    parameter logic [7:0] THRESHOLD_INIT = 8'd64
) (
    input  logic                              clk_25_vga,
    input  logic                              arst_n,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [3:0]                        paddr,
    input  logic [31:0]                       pwdata,
    output logic [31:0]                       prdata,
    output logic                              pready,
    output logic                              pslverr,
    input  logic                              wr_en,
    input  logic [cam_display_pkg::ADDR_W-1:0] wr_addr,
    input  logic [cam_display_pkg::PIX_W-1:0]  wr_data,
    output logic [7:0]                        vga_r,
    output logic [7:0]                        vga_g,
    output logic [7:0]                        vga_b,
    output logic                              vga_hsync,
    output logic                              vga_vsync,
    output logic                              vga_blank_n
);
    import cam_display_pkg::*;

    logic [ADDR_W-1:0] rd_addr;
    logic [PIX_W-1:0]  rd_data;
    logic              hsync_raw;
    logic              vsync_raw;
    logic              blank_n_raw;
    logic              frame_start;
    mode_e             mode;
    logic [7:0]        threshold;

    vga_timing u_vga_timing (
        .clk_25_vga  (clk_25_vga),
        .arst_n      (arst_n),
        .rd_addr     (rd_addr),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw),
        .blank_n_raw (blank_n_raw),
        .frame_start (frame_start)
    );

    frame_buffer u_frame_buffer (
        .clk_25_vga (clk_25_vga),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    pixel_process u_pixel_process (
        .clk_25_vga  (clk_25_vga),
        .arst_n      (arst_n),
        .rd_data     (rd_data),
        .mode        (mode),
        .threshold   (threshold),
        .hsync_raw   (hsync_raw),
        .vsync_raw   (vsync_raw),
        .blank_n_raw (blank_n_raw),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_blank_n (vga_blank_n)
    );

    apb_regs #(
        .THRESHOLD_INIT (THRESHOLD_INIT)
    ) u_apb_regs (
        .clk_25_vga  (clk_25_vga),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .frame_start (frame_start),
        .mode        (mode),
        .threshold   (threshold)
    );

endmodule

/* hw/apb_regs.sv */
`timescale 1ns/1ps

module apb_regs #(
    parameter logic [7:0] THRESHOLD_INIT = 8'd64
) (
    input  logic                   clk_25_vga,
    input  logic                   arst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [3:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   frame_start,
    output cam_display_pkg::mode_e mode,
    output logic [7:0]             threshold
);
    import cam_display_pkg::*;

    logic        setup;
    logic        access;
    logic        addr_ok;
    logic        err;
    logic [31:0] rd_mux;
    logic [15:0] frame_cnt;

    assign setup  = psel && !penable;
    assign access = psel && penable;
    assign pready = 1'b1;  // no wait states

    always_comb begin
        case (paddr)
            REG_CTRL, REG_THRESHOLD, REG_STATUS: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    assign err = !addr_ok || (pwrite && (paddr == REG_STATUS));  // status is read-only

    always_comb begin
        case (paddr)
            REG_CTRL:      rd_mux = {30'd0, mode};
            REG_THRESHOLD: rd_mux = {24'd0, threshold};
            REG_STATUS:    rd_mux = {16'd0, frame_cnt};
            default:       rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            mode      <= MODE_RGB;
            threshold <= THRESHOLD_INIT;
            frame_cnt <= '0;
            prdata    <= '0;
            pslverr   <= 1'b0;
        end else begin
            if (access && pwrite && !err) begin
                if (paddr == REG_CTRL) begin
                    mode <= mode_e'(pwdata[1:0]);
                end else begin
                    threshold <= pwdata[7:0];
                end
            end
            if (frame_start) begin
                frame_cnt <= frame_cnt + 16'd1;  // wraps
            end
            // sampled in setup, held through the access cycle
            prdata  <= (setup && !pwrite && !err) ? rd_mux : '0;
            pslverr <= setup && err;
        end
    end

endmodule

/* hw/pixel_process.sv */
`timescale 1ns/1ps

module pixel_process (
    input  logic                             clk_25_vga,
    input  logic                             arst_n,
    input  logic [cam_display_pkg::PIX_W-1:0] rd_data,
    input  cam_display_pkg::mode_e           mode,
    input  logic [7:0]                       threshold,
    input  logic                             hsync_raw,
    input  logic                             vsync_raw,
    input  logic                             blank_n_raw,
    output logic [7:0]                       vga_r,
    output logic [7:0]                       vga_g,
    output logic [7:0]                       vga_b,
    output logic                             vga_hsync,
    output logic                             vga_vsync,
    output logic                             vga_blank_n
);
    import cam_display_pkg::*;

    // blank tap lined up with rd_data, one stage before the outputs
    localparam int BLANK_TAP = SYNC_ALIGN - PROC_LAT - 1;

    logic [SYNC_ALIGN-1:0] hs_pipe;
    logic [SYNC_ALIGN-1:0] vs_pipe;
    logic [SYNC_ALIGN-1:0] bl_pipe;

    logic [7:0]  r8;
    logic [7:0]  g8;
    logic [7:0]  b8;
    logic [15:0] gray_sum;
    logic [7:0]  gray;
    logic [7:0]  bin;
    logic [7:0]  sel_r;
    logic [7:0]  sel_g;
    logic [7:0]  sel_b;

    // rgb565 -> rgb888, low bits filled with ones
    assign r8 = {rd_data[15:11], 3'b111};
    assign g8 = {rd_data[10:5], 2'b11};
    assign b8 = {rd_data[4:0], 3'b111};

    // weights sum to 252, result stays below 256
    assign gray_sum = 16'd76 * {8'd0, r8} + 16'd150 * {8'd0, g8} + 16'd26 * {8'd0, b8};
    assign gray     = gray_sum[15:8];
    assign bin      = (gray >= threshold) ? 8'hff : 8'h00;

    always_comb begin
        case (mode)
            MODE_GRAY: begin
                sel_r = gray;
                sel_g = gray;
                sel_b = gray;
            end
            MODE_BINARY: begin
                sel_r = bin;
                sel_g = bin;
                sel_b = bin;
            end
            default: begin  // rgb and reserved
                sel_r = r8;
                sel_g = g8;
                sel_b = b8;
            end
        endcase
    end

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            hs_pipe <= '1;
            vs_pipe <= '1;
            bl_pipe <= '0;
            vga_r   <= '0;
            vga_g   <= '0;
            vga_b   <= '0;
        end else begin
            hs_pipe <= {hs_pipe[SYNC_ALIGN-2:0], hsync_raw};
            vs_pipe <= {vs_pipe[SYNC_ALIGN-2:0], vsync_raw};
            bl_pipe <= {bl_pipe[SYNC_ALIGN-2:0], blank_n_raw};
            // black outside the active area
            vga_r   <= bl_pipe[BLANK_TAP] ? sel_r : 8'h00;
            vga_g   <= bl_pipe[BLANK_TAP] ? sel_g : 8'h00;
            vga_b   <= bl_pipe[BLANK_TAP] ? sel_b : 8'h00;
        end
    end

    assign vga_hsync   = hs_pipe[SYNC_ALIGN-1];
    assign vga_vsync   = vs_pipe[SYNC_ALIGN-1];
    assign vga_blank_n = bl_pipe[SYNC_ALIGN-1];

endmodule

/* hw/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer (
    input  logic                              clk_25_vga,
    input  logic                              wr_en,
    input  logic [cam_display_pkg::ADDR_W-1:0] wr_addr,
    input  logic [cam_display_pkg::PIX_W-1:0]  wr_data,
    input  logic [cam_display_pkg::ADDR_W-1:0] rd_addr,
    output logic [cam_display_pkg::PIX_W-1:0]  rd_data
);
    import cam_display_pkg::*;

    logic [PIX_W-1:0] mem [BUF_DEPTH];
    logic [PIX_W-1:0] rd_pipe [MEM_RD_LAT];  // ram read then output regs

    always_ff @(posedge clk_25_vga) begin
        if (wr_en && (wr_addr < ADDR_W'(BUF_DEPTH))) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read-first: same-address write in this cycle is not seen
    always_ff @(posedge clk_25_vga) begin
        rd_pipe[0] <= mem[rd_addr];
        for (int i = 1; i < MEM_RD_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign rd_data = rd_pipe[MEM_RD_LAT-1];

endmodule

/* hw/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing (
    input  logic                              clk_25_vga,
    input  logic                              arst_n,
    output logic [cam_display_pkg::ADDR_W-1:0] rd_addr,
    output logic                              hsync_raw,
    output logic                              vsync_raw,
    output logic                              blank_n_raw,
    output logic                              frame_start
);
    import cam_display_pkg::*;

    localparam logic [9:0] H_LAST    = 10'(H_TOTAL - 1);
    localparam logic [9:0] V_LAST    = 10'(V_TOTAL - 1);
    localparam logic [9:0] H_ACT     = 10'(H_ACTIVE);
    localparam logic [9:0] V_ACT     = 10'(V_ACTIVE);
    localparam logic [9:0] HS_START  = 10'(H_ACTIVE + H_FRONT);
    localparam logic [9:0] HS_END    = 10'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [9:0] VS_START  = 10'(V_ACTIVE + V_FRONT);
    localparam logic [9:0] VS_END    = 10'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [9:0]        h_cnt;   // column 0..799
    logic [9:0]        v_cnt;   // line 0..524
    logic              active;
    logic [ADDR_W-1:0] addr_next;

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    assign active = (h_cnt < H_ACT) && (v_cnt < V_ACT);

    // 2x upscale, drop the lsb of line and column
    assign addr_next = active ?
        ADDR_W'(v_cnt[9:1]) * ADDR_W'(BUF_W) + ADDR_W'(h_cnt[9:1]) : '0;

    always_ff @(posedge clk_25_vga or negedge arst_n) begin
        if (!arst_n) begin
            rd_addr     <= '0;
            hsync_raw   <= 1'b1;  // syncs idle high
            vsync_raw   <= 1'b1;
            blank_n_raw <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            rd_addr     <= addr_next;
            hsync_raw   <= !((h_cnt >= HS_START) && (h_cnt < HS_END));
            vsync_raw   <= !((v_cnt >= VS_START) && (v_cnt < VS_END));
            blank_n_raw <= active;
            frame_start <= (h_cnt == '0) && (v_cnt == '0);  // first active pixel
        end
    end

endmodule

/* hw/cam_display_pkg.sv */
package cam_display_pkg;

    // 640x480 at 60 Hz, 25 MHz pixel clock
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

    // stored picture is half the screen in each direction
    localparam int BUF_W     = 320;
    localparam int BUF_H     = 240;
    localparam int BUF_DEPTH = BUF_W * BUF_H;  // 76800 words
    localparam int ADDR_W    = 17;
    localparam int PIX_W     = 16;             // rgb565

    localparam int MEM_RD_LAT = 2;  // address reg + output reg
    localparam int PROC_LAT   = 1;  // colour register
    localparam int SYNC_ALIGN = MEM_RD_LAT + PROC_LAT;

    // value 3 is reserved, shown as rgb
    typedef enum logic [1:0] {
        MODE_RGB    = 2'd0,
        MODE_GRAY   = 2'd1,
        MODE_BINARY = 2'd2
    } mode_e;

    typedef enum logic [3:0] {
        REG_CTRL      = 4'h0,
        REG_THRESHOLD = 4'h4,
        REG_STATUS    = 4'h8
    } reg_addr_e;

endpackage
